// File: ex_cfg_pkg.sv
// Execute stage widths and cause codes

package ex_cfg_pkg;

    // ------------------------------------------------------------------------
    // Data path widths
    // ------------------------------------------------------------------------
    // Data and address width
    localparam int unsigned XLEN = 32;

    // Scoreboard transaction ID
    localparam int unsigned TRANS_ID_BITS = 3;

    // Address space ID captured for SFENCE.VMA
    localparam int unsigned ASID_WIDTH = 9;

    // CSR address field of the instruction
    localparam int unsigned CSR_ADDR_BITS = 12;

    // ------------------------------------------------------------------------
    // Exception causes
    // ------------------------------------------------------------------------
    localparam int unsigned CAUSE_BITS = 5;

    // Taken branch or jump to an odd address
    localparam logic [CAUSE_BITS-1:0] CAUSE_INSTR_MISALIGNED = 5'd0;

endpackage

// File: ex_op_pkg.sv
// Execute stage operation encoding

package ex_op_pkg;

    localparam int unsigned OP_BITS = 6;

    // ------------------------------------------------------------------------
    // Operations, grouped by the unit that serves them
    // ------------------------------------------------------------------------
    typedef enum logic [OP_BITS-1:0] {
        // ALU arithmetic, logic, shifts and set-less-than
        ADD, SUB, XOR, OR, AND, SLL, SRL, SRA, SLT, SLTU,
        // Branch comparisons, evaluated by the ALU
        EQ, NE, LTS, GES, LTU, GEU,
        // Indirect jump
        JALR,
        // CSR buffer
        CSR_WRITE, CSR_READ, CSR_SET, CSR_CLEAR,
        SFENCE_VMA,
        // Multiplier
        MUL, MULH, MULHU, MULHSU
    } fu_op_e;

    // Multiplier operand a is signed for MULH and MULHSU
    function automatic logic mult_a_signed(fu_op_e op);
        return (op == MULH) || (op == MULHSU);
    endfunction

    // Only MULH treats operand b as signed
    function automatic logic mult_b_signed(fu_op_e op);
        return (op == MULH);
    endfunction

endpackage

// File: alu.sv
// Integer ALU with branch compare

`timescale 1ns/1ps

module alu import ex_cfg_pkg::*, ex_op_pkg::*; (
    input  fu_op_e            fu_op_i,
    input  logic [XLEN-1:0]   operand_a_i,
    input  logic [XLEN-1:0]   operand_b_i,
    output logic [XLEN-1:0]   result_o,
    output logic              branch_res_o
);

    logic            cmp_signed;
    logic [XLEN-1:0] cmp_a;
    logic [XLEN-1:0] cmp_b;
    logic            less;
    logic            equal;
    logic [4:0]      shamt;

    // ------------------------------------------------------------------------
    // Comparator
    // ------------------------------------------------------------------------
    // Signed compares flip the sign bits and use the unsigned path
    assign cmp_signed = (fu_op_i == SLT) || (fu_op_i == LTS) || (fu_op_i == GES);
    assign cmp_a      = {operand_a_i[XLEN-1] ^ cmp_signed, operand_a_i[XLEN-2:0]};
    assign cmp_b      = {operand_b_i[XLEN-1] ^ cmp_signed, operand_b_i[XLEN-2:0]};
    assign less       = cmp_a < cmp_b;
    assign equal      = operand_a_i == operand_b_i;

    always_comb begin
        unique case (fu_op_i)
            EQ:       branch_res_o = equal;
            NE:       branch_res_o = ~equal;
            LTS, LTU: branch_res_o = less;
            GES, GEU: branch_res_o = ~less;
            default:  branch_res_o = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------------
    assign shamt = operand_b_i[4:0];

    always_comb begin
        unique case (fu_op_i)
            ADD:       result_o = operand_a_i + operand_b_i;
            SUB:       result_o = operand_a_i - operand_b_i;
            XOR:       result_o = operand_a_i ^ operand_b_i;
            OR:        result_o = operand_a_i | operand_b_i;
            AND:       result_o = operand_a_i & operand_b_i;
            SLL:       result_o = operand_a_i << shamt;
            SRL:       result_o = operand_a_i >> shamt;
            SRA:       result_o = $unsigned($signed(operand_a_i) >>> shamt);
            SLT, SLTU: result_o = {{(XLEN-1){1'b0}}, less};
            default:   result_o = '0;
        endcase
    end

endmodule

// File: branch_unit.sv
// Branch and jump resolution

`timescale 1ns/1ps

module branch_unit import ex_cfg_pkg::*, ex_op_pkg::*; (
    input  fu_op_e                 fu_op_i,
    input  logic [XLEN-1:0]        operand_a_i,
    input  logic [XLEN-1:0]        imm_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic                   is_compressed_i,
    input  logic                   branch_valid_i,
    input  logic                   branch_res_i,
    input  logic                   bp_taken_i,
    input  logic [XLEN-1:0]        bp_target_i,
    output logic [XLEN-1:0]        result_o,
    output logic                   resolve_o,
    output logic [XLEN-1:0]        res_pc_o,
    output logic [XLEN-1:0]        res_target_o,
    output logic                   res_taken_o,
    output logic                   res_mispredict_o,
    output logic                   ex_valid_o,
    output logic [CAUSE_BITS-1:0]  ex_cause_o,
    output logic [XLEN-1:0]        ex_tval_o
);

    logic            is_jalr;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] next_pc;
    logic            taken;

    assign is_jalr  = fu_op_i == JALR;
    assign jalr_sum = operand_a_i + imm_i;
    // JALR clears bit 0 of its target
    assign target   = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
    assign next_pc  = pc_i + (is_compressed_i ? 32'd2 : 32'd4);
    assign taken    = is_jalr | branch_res_i;

    // Link address goes back through the write port
    assign result_o = next_pc;

    assign resolve_o        = branch_valid_i;
    assign res_pc_o         = pc_i;
    assign res_taken_o      = taken;
    assign res_target_o     = taken ? target : next_pc;
    assign res_mispredict_o = branch_valid_i
                            & ((taken != bp_taken_i) | (taken & (bp_target_i != target)));

    // Odd target of a taken branch
    assign ex_valid_o = branch_valid_i & taken & target[0];
    assign ex_cause_o = CAUSE_INSTR_MISALIGNED;
    assign ex_tval_o  = target;

endmodule

// File: csr_buffer.sv
// Single-entry CSR address buffer

`timescale 1ns/1ps

module csr_buffer import ex_cfg_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     csr_valid_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    input  logic                     csr_commit_i,
    output logic                     csr_ready_o,
    output logic [XLEN-1:0]          csr_result_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                     valid_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    // Full buffer blocks the issue port until commit
    assign csr_ready_o  = ~valid_q;
    assign csr_result_o = operand_a_i;
    assign csr_addr_o   = valid_q ? addr_q : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (csr_valid_i) begin
            valid_q <= 1'b1;
        end else if (csr_commit_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= operand_b_i[CSR_ADDR_BITS-1:0];
        end
    end

endmodule

// File: mult.sv
// One-cycle multiplier

`timescale 1ns/1ps

module mult import ex_cfg_pkg::*, ex_op_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     mult_valid_i,
    input  fu_op_e                   fu_op_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    output logic [XLEN-1:0]          result_o,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o
);

    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] product;

    // Extra top bit carries the sign, or zero for unsigned operands
    assign a_ext   = {mult_a_signed(fu_op_i) & operand_a_i[XLEN-1], operand_a_i};
    assign b_ext   = {mult_b_signed(fu_op_i) & operand_b_i[XLEN-1], operand_b_i};
    assign product = a_ext * b_ext;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_o   <= (fu_op_i == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
            trans_id_o <= trans_id_i;
        end
    end

endmodule

// File: flu_ctrl.sv
// Fixed-latency unit control and write-back

`timescale 1ns/1ps

module flu_ctrl import ex_cfg_pkg::*, ex_op_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    input  fu_op_e                   fu_op_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    input  logic [XLEN-1:0]          rs1_fwd_i,
    input  logic [XLEN-1:0]          rs2_fwd_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    output logic [XLEN-1:0]          alu_a_o,
    output logic [XLEN-1:0]          alu_b_o,
    output logic [XLEN-1:0]          mult_a_o,
    output logic [XLEN-1:0]          mult_b_o,
    input  logic [XLEN-1:0]          alu_result_i,
    input  logic [XLEN-1:0]          branch_result_i,
    input  logic [XLEN-1:0]          csr_result_i,
    input  logic                     csr_ready_i,
    input  logic [XLEN-1:0]          mult_result_i,
    input  logic                     mult_valid_i_d,
    input  logic [TRANS_ID_BITS-1:0] mult_trans_id_i,
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                     flu_valid_o,
    output logic                     flu_ready_o,
    output logic [XLEN-1:0]          flush_vaddr_o,
    output logic [ASID_WIDTH-1:0]    flush_asid_o
);

    logic alu_sel;
    logic sfence_issue;
    logic sfence_q;

    // ------------------------------------------------------------------------
    // Operand silencing
    // ------------------------------------------------------------------------
    // Idle units see zero so their logic does not toggle
    assign alu_sel  = alu_valid_i | branch_valid_i;
    assign alu_a_o  = alu_sel ? operand_a_i : '0;
    assign alu_b_o  = alu_sel ? operand_b_i : '0;
    assign mult_a_o = mult_valid_i ? operand_a_i : '0;
    assign mult_b_o = mult_valid_i ? operand_b_i : '0;

    // ------------------------------------------------------------------------
    // Write-back port
    // ------------------------------------------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i_d;
    assign flu_ready_o = csr_ready_i;

    always_comb begin
        // Link address unless a higher priority unit writes
        flu_result_o   = branch_result_i;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i_d) begin
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    // ------------------------------------------------------------------------
    // SFENCE.VMA operand capture
    // ------------------------------------------------------------------------
    assign sfence_issue = csr_valid_i & (fu_op_i == SFENCE_VMA);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sfence_q <= 1'b0;
        end else if (flush_i) begin
            sfence_q <= 1'b0;
        end else if (sfence_issue) begin
            sfence_q <= 1'b1;
        end
    end

    // Freeze from the issue cycle on, so the pre-issue operands are kept
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_vaddr_o <= '0;
            flush_asid_o  <= '0;
        end else if (!sfence_q && !sfence_issue) begin
            flush_vaddr_o <= rs1_fwd_i;
            flush_asid_o  <= rs2_fwd_i[ASID_WIDTH-1:0];
        end
    end

endmodule

// File: ex_stage.sv
// Execute stage fixed-latency units

`timescale 1ns/1ps

module ex_stage import ex_cfg_pkg::*, ex_op_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  fu_op_e                   fu_op_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [XLEN-1:0]          pc_i,
    input  logic                     is_compressed_i,
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    input  logic                     bp_taken_i,
    input  logic [XLEN-1:0]          bp_target_i,
    input  logic                     csr_commit_i,
    input  logic                     flush_i,
    input  logic [XLEN-1:0]          rs1_fwd_i,
    input  logic [XLEN-1:0]          rs2_fwd_i,
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                     flu_valid_o,
    output logic                     flu_ready_o,
    output logic                     resolve_branch_o,
    output logic [XLEN-1:0]          res_pc_o,
    output logic [XLEN-1:0]          res_target_o,
    output logic                     res_taken_o,
    output logic                     res_mispredict_o,
    output logic                     flu_ex_valid_o,
    output logic [CAUSE_BITS-1:0]    flu_ex_cause_o,
    output logic [XLEN-1:0]          flu_ex_tval_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o,
    output logic [XLEN-1:0]          flush_vaddr_o,
    output logic [ASID_WIDTH-1:0]    flush_asid_o
);

    logic [XLEN-1:0]          alu_a;
    logic [XLEN-1:0]          alu_b;
    logic [XLEN-1:0]          mult_a;
    logic [XLEN-1:0]          mult_b;
    logic [XLEN-1:0]          alu_result;
    logic                     alu_branch_res;
    logic [XLEN-1:0]          branch_result;
    logic [XLEN-1:0]          csr_result;
    logic                     csr_ready;
    logic [XLEN-1:0]          mult_result;
    logic                     mult_valid;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;

    flu_ctrl i_flu_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .alu_valid_i     (alu_valid_i),
        .branch_valid_i  (branch_valid_i),
        .csr_valid_i     (csr_valid_i),
        .mult_valid_i    (mult_valid_i),
        .fu_op_i         (fu_op_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .rs1_fwd_i       (rs1_fwd_i),
        .rs2_fwd_i       (rs2_fwd_i),
        .trans_id_i      (trans_id_i),
        .alu_a_o         (alu_a),
        .alu_b_o         (alu_b),
        .mult_a_o        (mult_a),
        .mult_b_o        (mult_b),
        .alu_result_i    (alu_result),
        .branch_result_i (branch_result),
        .csr_result_i    (csr_result),
        .csr_ready_i     (csr_ready),
        .mult_result_i   (mult_result),
        .mult_valid_i_d  (mult_valid),
        .mult_trans_id_i (mult_trans_id),
        .flu_result_o    (flu_result_o),
        .flu_trans_id_o  (flu_trans_id_o),
        .flu_valid_o     (flu_valid_o),
        .flu_ready_o     (flu_ready_o),
        .flush_vaddr_o   (flush_vaddr_o),
        .flush_asid_o    (flush_asid_o)
    );

    // ------------------------------------------------------------------------
    // Single-cycle units
    // ------------------------------------------------------------------------
    alu i_alu (
        .fu_op_i      (fu_op_i),
        .operand_a_i  (alu_a),
        .operand_b_i  (alu_b),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Branch unit operands stay ungated to keep the path short
    branch_unit i_branch_unit (
        .fu_op_i          (fu_op_i),
        .operand_a_i      (operand_a_i),
        .imm_i            (imm_i),
        .pc_i             (pc_i),
        .is_compressed_i  (is_compressed_i),
        .branch_valid_i   (branch_valid_i),
        .branch_res_i     (alu_branch_res),
        .bp_taken_i       (bp_taken_i),
        .bp_target_i      (bp_target_i),
        .result_o         (branch_result),
        .resolve_o        (resolve_branch_o),
        .res_pc_o         (res_pc_o),
        .res_target_o     (res_target_o),
        .res_taken_o      (res_taken_o),
        .res_mispredict_o (res_mispredict_o),
        .ex_valid_o       (flu_ex_valid_o),
        .ex_cause_o       (flu_ex_cause_o),
        .ex_tval_o        (flu_ex_tval_o)
    );

    // ------------------------------------------------------------------------
    // Registered units
    // ------------------------------------------------------------------------
    csr_buffer i_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    mult i_mult (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (mult_valid_i),
        .fu_op_i      (fu_op_i),
        .operand_a_i  (mult_a),
        .operand_b_i  (mult_b),
        .trans_id_i   (trans_id_i),
        .result_o     (mult_result),
        .valid_o      (mult_valid),
        .trans_id_o   (mult_trans_id)
    );

endmodule

// File: ex_stage_assert.sv
// Execute stage output properties

`timescale 1ns/1ps

module ex_stage_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic alu_valid_i,
    input logic branch_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    input logic flush_i,
    input logic flu_valid_o,
    input logic flu_ready_o,
    input logic resolve_branch_o,
    input logic res_mispredict_o,
    input logic flu_ex_valid_o
);

    logic any_strobe;

    assign any_strobe = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

    // Write-back needs an issue now or a multiply one cycle earlier
    valid_has_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flu_valid_o |-> (any_strobe || $past(any_strobe)))
        else $error("flu_valid_o high with no strobe in this or the previous cycle");

    // A CSR issue fills the buffer
    ready_after_csr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (csr_valid_i && !flush_i) |=> !flu_ready_o)
        else $error("flu_ready_o still high the cycle after a CSR issue");

    // Resolution, mispredict and exception only for an issued branch
    resolve_with_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (resolve_branch_o || res_mispredict_o || flu_ex_valid_o) |-> branch_valid_i)
        else $error("Branch resolution output high without branch_valid_i");

endmodule

bind ex_stage ex_stage_assert u_ex_stage_assert (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .alu_valid_i      (alu_valid_i),
    .branch_valid_i   (branch_valid_i),
    .csr_valid_i      (csr_valid_i),
    .mult_valid_i     (mult_valid_i),
    .flush_i          (flush_i),
    .flu_valid_o      (flu_valid_o),
    .flu_ready_o      (flu_ready_o),
    .resolve_branch_o (resolve_branch_o),
    .res_mispredict_o (res_mispredict_o),
    .flu_ex_valid_o   (flu_ex_valid_o)
);

// File: tb_ex_stage.sv
// Execute stage testbench

`timescale 1ns/1ps

module tb_ex_stage import ex_cfg_pkg::*, ex_op_pkg::*; ();

    localparam int    CLK_PERIOD = 4;
    localparam int    RST_CYCLES = 4;
    localparam int    MAX_CASES  = 64;
    localparam int    N_FIELDS   = 21;
    localparam string CASES_FILE = "ex_cases.txt";

    // Column positions in one line of the cases file
    localparam int F_OP    = 0;
    localparam int F_STRB  = 1;
    localparam int F_CTL   = 2;
    localparam int F_TID   = 3;
    localparam int F_OPA   = 4;
    localparam int F_OPB   = 5;
    localparam int F_IMM   = 6;
    localparam int F_PC    = 7;
    localparam int F_BPTGT = 8;
    localparam int F_RS1   = 9;
    localparam int F_RS2   = 10;
    localparam int F_MASK  = 11;
    localparam int F_VRR   = 12;
    localparam int F_RES   = 13;
    localparam int F_ID    = 14;
    localparam int F_TMX   = 15;
    localparam int F_TGT   = 16;
    localparam int F_CAUSE = 17;
    localparam int F_CSRA  = 18;
    localparam int F_FVA   = 19;
    localparam int F_FASID = 20;

    logic                     clk_i;
    logic                     rst_ni;
    fu_op_e                   fu_op_i;
    logic [XLEN-1:0]          operand_a_i;
    logic [XLEN-1:0]          operand_b_i;
    logic [XLEN-1:0]          imm_i;
    logic [TRANS_ID_BITS-1:0] trans_id_i;
    logic [XLEN-1:0]          pc_i;
    logic                     is_compressed_i;
    logic                     alu_valid_i;
    logic                     branch_valid_i;
    logic                     csr_valid_i;
    logic                     mult_valid_i;
    logic                     bp_taken_i;
    logic [XLEN-1:0]          bp_target_i;
    logic                     csr_commit_i;
    logic                     flush_i;
    logic [XLEN-1:0]          rs1_fwd_i;
    logic [XLEN-1:0]          rs2_fwd_i;
    logic [XLEN-1:0]          flu_result_o;
    logic [TRANS_ID_BITS-1:0] flu_trans_id_o;
    logic                     flu_valid_o;
    logic                     flu_ready_o;
    logic                     resolve_branch_o;
    logic [XLEN-1:0]          res_pc_o;
    logic [XLEN-1:0]          res_target_o;
    logic                     res_taken_o;
    logic                     res_mispredict_o;
    logic                     flu_ex_valid_o;
    logic [CAUSE_BITS-1:0]    flu_ex_cause_o;
    logic [XLEN-1:0]          flu_ex_tval_o;
    logic [CSR_ADDR_BITS-1:0] csr_addr_o;
    logic [XLEN-1:0]          flush_vaddr_o;
    logic [ASID_WIDTH-1:0]    flush_asid_o;

    logic [31:0] case_mem [MAX_CASES][N_FIELDS];
    int          n_cases     = 0;
    int          cur_case    = 0;
    int          n_checks    = 0;
    int          value_errs  = 0;
    int          other_errs  = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    int          idx;

    ex_stage u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // Watchdog armed once the number of cases is known
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic init_inputs();
        fu_op_i         = ADD;
        operand_a_i     = '0;
        operand_b_i     = '0;
        imm_i           = '0;
        trans_id_i      = '0;
        pc_i            = '0;
        is_compressed_i = 1'b0;
        alu_valid_i     = 1'b0;
        branch_valid_i  = 1'b0;
        csr_valid_i     = 1'b0;
        mult_valid_i    = 1'b0;
        bp_taken_i      = 1'b0;
        bp_target_i     = '0;
        csr_commit_i    = 1'b0;
        flush_i         = 1'b0;
        rs1_fwd_i       = '0;
        rs2_fwd_i       = '0;
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        int          line_no;
        int          i;
        string       line;
        logic [31:0] f [N_FIELDS];
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", CASES_FILE);
            other_errs++;
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
            if (n != N_FIELDS) begin
                $display("Line %0d of %s has %0d fields instead of %0d",
                         line_no, CASES_FILE, n, N_FIELDS);
                other_errs++;
            end else if (n_cases >= MAX_CASES) begin
                $display("Too many cases in %s, line %0d is ignored", CASES_FILE, line_no);
                other_errs++;
            end else begin
                for (i = 0; i < N_FIELDS; i++) begin
                    case_mem[n_cases][i] = f[i];
                end
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("No cases were found in %s", CASES_FILE);
            other_errs++;
        end
    endtask

    task automatic drive_case(input int c);
        logic [3:0] strb;
        logic [3:0] ctl;
        strb            = case_mem[c][F_STRB][3:0];
        ctl             = case_mem[c][F_CTL][3:0];
        fu_op_i         = fu_op_e'(case_mem[c][F_OP][OP_BITS-1:0]);
        alu_valid_i     = strb[3];
        branch_valid_i  = strb[2];
        csr_valid_i     = strb[1];
        mult_valid_i    = strb[0];
        is_compressed_i = ctl[3];
        bp_taken_i      = ctl[2];
        csr_commit_i    = ctl[1];
        flush_i         = ctl[0];
        trans_id_i      = case_mem[c][F_TID][TRANS_ID_BITS-1:0];
        operand_a_i     = case_mem[c][F_OPA];
        operand_b_i     = case_mem[c][F_OPB];
        imm_i           = case_mem[c][F_IMM];
        pc_i            = case_mem[c][F_PC];
        bp_target_i     = case_mem[c][F_BPTGT];
        rs1_fwd_i       = case_mem[c][F_RS1];
        rs2_fwd_i       = case_mem[c][F_RS2];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %s: got %h, expected %h (case %0d at %0t)",
                     name, got, exp, cur_case, $time);
        end
    endtask

    task automatic compare_case(input int c);
        logic [3:0] mask;
        logic [2:0] vrr;
        logic [2:0] tmx;
        mask = case_mem[c][F_MASK][3:0];
        vrr  = case_mem[c][F_VRR][2:0];
        tmx  = case_mem[c][F_TMX][2:0];
        check_value("flu_valid_o", 32'(flu_valid_o), 32'(vrr[2]));
        check_value("flu_ready_o", 32'(flu_ready_o), 32'(vrr[1]));
        check_value("resolve_branch_o", 32'(resolve_branch_o), 32'(vrr[0]));
        if (mask[0]) begin
            check_value("flu_result_o", flu_result_o, case_mem[c][F_RES]);
            check_value("flu_trans_id_o", 32'(flu_trans_id_o), case_mem[c][F_ID]);
        end
        // Branch resolution and the misaligned target exception
        if (mask[1]) begin
            check_value("res_taken_o", 32'(res_taken_o), 32'(tmx[2]));
            check_value("res_mispredict_o", 32'(res_mispredict_o), 32'(tmx[1]));
            check_value("res_target_o", res_target_o, case_mem[c][F_TGT]);
            check_value("res_pc_o", res_pc_o, case_mem[c][F_PC]);
            check_value("flu_ex_valid_o", 32'(flu_ex_valid_o), 32'(tmx[0]));
            if (tmx[0]) begin
                check_value("flu_ex_cause_o", 32'(flu_ex_cause_o), case_mem[c][F_CAUSE]);
                check_value("flu_ex_tval_o", flu_ex_tval_o, case_mem[c][F_TGT]);
            end
        end
        if (mask[2]) begin
            check_value("csr_addr_o", 32'(csr_addr_o), case_mem[c][F_CSRA]);
        end
        if (mask[3]) begin
            check_value("flush_vaddr_o", flush_vaddr_o, case_mem[c][F_FVA]);
            check_value("flush_asid_o", 32'(flush_asid_o), case_mem[c][F_FASID]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        init_inputs();
        rst_ni = 1'b0;
        load_cases();
        if (other_errs == 0) begin
            cycle_limit = n_cases * 4 + 20;
            repeat (RST_CYCLES) @(posedge clk_i);
            @(negedge clk_i);
            rst_ni = 1'b1;
            // Drive one case per cycle and sample just before the next rising edge
            for (idx = 0; idx < n_cases; idx++) begin
                @(negedge clk_i);
                cur_case = idx + 1;
                drive_case(idx);
                #(CLK_PERIOD/2 - 1);
                compare_case(idx);
            end
            @(negedge clk_i);
            init_inputs();
        end
        $display("Cases: %0d, checks: %0d, value errors: %0d, other errors: %0d",
                 n_cases, n_checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: ex_cases.txt
# op strb(alu,br,csr,mul) ctl(comp,bp_taken,commit,flush) tid opa opb imm pc bp_target rs1 rs2
# mask(res,br,csr,sfence) vrr(valid,ready,resolve) res id tmx(taken,misp,exc) tgt cause csr fva asid
0 8 0 1 7fffffff 1 0 0 0 0 0  1 6 80000000 1 0 0 0 0 0 0
1 8 0 2 5 7 0 0 0 0 0  1 6 fffffffe 2 0 0 0 0 0 0
2 8 0 3 f0f0f0f0 ff00ff00 0 0 0 0 0  1 6 0ff00ff0 3 0 0 0 0 0 0
3 8 0 4 12340000 5678 0 0 0 0 0  1 6 12345678 4 0 0 0 0 0 0
4 8 0 5 ff00ff00 0f0f0f0f 0 0 0 0 0  1 6 0f000f00 5 0 0 0 0 0 0
5 8 0 6 1 3f 0 0 0 0 0  1 6 80000000 6 0 0 0 0 0 0
6 8 0 7 80000000 4 0 0 0 0 0  1 6 08000000 7 0 0 0 0 0 0
7 8 0 0 80000000 4 0 0 0 0 0  1 6 f8000000 0 0 0 0 0 0 0
8 8 0 1 ffffffff 1 0 0 0 0 0  1 6 1 1 0 0 0 0 0 0
9 8 0 2 ffffffff 1 0 0 0 0 0  1 6 0 2 0 0 0 0 0 0
a 4 4 3 5 5 40 1000 1040 0 0  3 7 1004 3 4 1040 0 0 0 0
b 4 c 4 5 5 80 2000 2080 0 0  3 7 2002 4 2 2002 0 0 0 0
c 4 4 5 ffffffff 1 fffffff0 3000 3010 0 0  3 7 3004 5 6 2ff0 0 0 0 0
f 4 0 6 ffffffff 1 8 4000 0 0 0  3 7 4004 6 6 4008 0 0 0 0
e 4 0 7 ffffffff 1 0 5000 0 0 0  3 7 5004 7 0 5004 0 0 0 0
d 4 4 0 1 ffffffff 10 6000 6010 0 0  3 7 6004 0 4 6010 0 0 0 0
10 4 c 1 8001 0 4 7000 8004 0 0  3 7 7002 1 4 8004 0 0 0 0
a 4 0 2 0 0 3 9000 0 0 0  3 7 9004 2 7 9003 0 0 0 0
11 2 0 3 deadbeef 305 0 0 0 0 0  5 6 deadbeef 3 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0  4 0 0 0 0 0 0 305 0 0
0 0 2 0 0 0 0 0 0 0 0  4 0 0 0 0 0 0 305 0 0
0 0 0 0 0 0 0 0 0 0 0  4 2 0 0 0 0 0 0 0 0
13 2 0 5 11 c00 0 0 0 0 0  5 6 11 5 0 0 0 0 0 0
0 0 1 0 0 0 0 0 0 0 0  4 0 0 0 0 0 0 c00 0 0
0 0 0 0 0 0 0 0 0 0 0  4 2 0 0 0 0 0 0 0 0
16 1 0 6 12345 1000 0 0 0 0 0  0 2 0 0 0 0 0 0 0 0
17 1 0 7 ffffffff ffffffff 0 0 0 0 0  1 6 12345000 6 0 0 0 0 0 0
18 1 0 0 ffffffff ffffffff 0 0 0 0 0  1 6 0 7 0 0 0 0 0 0
19 1 0 1 ffffffff 2 0 0 0 0 0  1 6 fffffffe 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0  1 6 ffffffff 1 0 0 0 0 0 0
16 1 1 2 3 5 0 0 0 0 0  0 2 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0  0 2 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 a0001000 1ff  8 2 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 a0002000 3a5  8 2 0 0 0 0 0 0 a0001000 1ff
15 2 0 3 0 0 0 0 0 b0003000 3c  9 6 0 3 0 0 0 0 a0002000 1a5
0 0 2 0 0 0 0 0 0 c0004000 155  8 0 0 0 0 0 0 0 a0002000 1a5
0 0 0 0 0 0 0 0 0 d0005000 0  8 2 0 0 0 0 0 0 a0002000 1a5
0 0 1 0 0 0 0 0 0 e0006000 0f0  8 2 0 0 0 0 0 0 a0002000 1a5
0 0 0 0 0 0 0 0 0 f0007000 1  8 2 0 0 0 0 0 0 a0002000 1a5
0 0 0 0 0 0 0 0 0 0 0  8 2 0 0 0 0 0 0 f0007000 1

// File: list.f
ex_cfg_pkg.sv
ex_op_pkg.sv
alu.sv
branch_unit.sv
csr_buffer.sv
mult.sv
flu_ctrl.sv
ex_stage.sv
ex_stage_assert.sv
tb_ex_stage.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
